//--- flist.f
s16_pkg.sv
s16_bus_if.sv
s16_mem_map.sv
s16_io_ports.sv
s16_data_return.sv
s16_main_bus.sv
s16_bus_checker.sv
tb_s16_main_bus.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator and run; the verdict comes from the simulation output
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_s16_main_bus -f flist.f -o sim_s16 &&
./obj_dir/sim_s16 | tee /dev/stderr | grep -q "Simulation finished: PASS" &&
echo "run_sim: passed" ||
{ echo "run_sim: failed"; exit 1; }

//--- s16_bus_checker.sv
/*
 * Bus rules bound into s16_main_bus. Sees the internal select struct,
 * so the I/O and tile bank selects take part as well.
 */
`timescale 1ns/10ps

module s16_bus_checker (
    input logic             clk,
    input logic             rst,
    input logic             as_n,
    input s16_pkg::s16_cs_t cs,
    input logic             dtack_n
);

    int assert_failures = 0;

    // Memory selects never overlap
    a_one_mem_sel: assert property (@(posedge clk) disable iff (rst)
        $onehot0({cs.rom, cs.ram, cs.vram, cs.chr, cs.obj, cs.pal}))
    else begin
        assert_failures++;
        $error("more than one memory select high");
    end

    a_sel_clear: assert property (@(posedge clk) disable iff (rst) as_n |=> (cs == '0))
    else begin
        assert_failures++;
        $error("select still high after as_n went high");
    end

    a_no_sel_no_ack: assert property (@(posedge clk) disable iff (rst) (cs == '0) |-> dtack_n)
    else begin
        assert_failures++;
        $error("dtack_n low with no select");   // Would hand the CPU a bogus cycle end
    end

endmodule

bind s16_main_bus s16_bus_checker u_bus_checker (
    .clk     (clk),
    .rst     (rst),
    .as_n    (as_n),
    .cs      (cs),
    .dtack_n (dtack_n)
);

//--- s16_bus_if.sv
/*
 * CPU bus inside the design. All strobes active low.
 * No clock here, the signals follow the top-level ports directly.
 */
`timescale 1ns/10ps

interface s16_bus_if;

    logic [s16_pkg::ADDR_W:1]   addr;    // Word address
    logic                       as_n;
    logic                       uds_n;
    logic                       lds_n;
    logic                       rnw;
    logic [s16_pkg::DATA_W-1:0] wdata;

    // Address decoder sees the whole cycle but no data
    modport decoder (
        input addr,
        input as_n,
        input uds_n,
        input lds_n,
        input rnw
    );

    // Peripherals only take lower-byte writes
    modport periph (
        input addr,
        input lds_n,
        input rnw,
        input wdata
    );

endinterface

//--- s16_data_return.sv
/*
 * Read data return and DTACK. DTACK waits as long as the selected
 * ROM or RAM reports not ready, there is no timeout here.
 */
`timescale 1ns/10ps

module s16_data_return (
    input  logic                          clk,
    input  logic                          rst,
    input  s16_pkg::s16_cs_t              cs,
    input  logic [s16_pkg::DATA_W-1:0]    ram_data,
    input  logic [s16_pkg::DATA_W-1:0]    rom_data,
    input  logic [s16_pkg::DATA_W-1:0]    char_dout,
    input  logic [s16_pkg::DATA_W-1:0]    pal_dout,
    input  logic [s16_pkg::DATA_W-1:0]    obj_dout,
    input  logic [7:0]                    cab_dout,
    input  logic                          ram_ok,
    input  logic                          rom_ok,
    output logic [s16_pkg::DATA_W-1:0]    cpu_din,
    output logic                          dtack_n
);

    logic ram_side;    // Work RAM and VRAM share one port
    logic bus_busy;
    logic any_sel;

    assign ram_side = cs.ram || cs.vram;
    assign bus_busy = (cs.rom && !rom_ok) || (ram_side && !ram_ok);
    assign any_sel  = cs.rom || ram_side || cs.chr || cs.obj || cs.pal || cs.io;

    // Tile bank write has nothing to wait for
    assign dtack_n = !((any_sel && !bus_busy) || cs.tbank);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cpu_din <= '0;
        end else if (ram_side) begin
            if (ram_ok)
                cpu_din <= ram_data;
        end else if (cs.rom) begin
            if (rom_ok)
                cpu_din <= rom_data;
        end else if (cs.chr) begin
            cpu_din <= char_dout;
        end else if (cs.pal) begin
            cpu_din <= pal_dout;
        end else if (cs.obj) begin
            cpu_din <= obj_dout;
        end else if (cs.io) begin
            cpu_din <= {s16_pkg::OPEN_BUS_BYTE, cab_dout};
        end
        // Unmapped addresses keep the last value
    end

endmodule

//--- s16_io_ports.sv
/*
 * Cabinet inputs, video control and tile bank registers.
 * Only lower-byte writes are decoded. Inputs are passed as given,
 * so their polarity is whatever the cabinet wiring supplies.
 */
`timescale 1ns/10ps

module s16_io_ports (
    input  logic             clk,
    input  logic             rst,
    s16_bus_if.periph        bus,
    input  s16_pkg::s16_cs_t cs,
    input  logic [7:0]       joystick1,
    input  logic [7:0]       joystick2,
    input  logic [7:0]       joystick3,
    input  logic [7:0]       joystick4,
    input  logic [3:0]       start_button,
    input  logic [3:0]       coin_input,
    input  logic             service,
    input  logic             dip_test,
    input  logic [7:0]       dipsw_a,
    input  logic [7:0]       dipsw_b,
    output logic [7:0]       cab_dout,
    output logic             flip,
    output logic             video_en,
    output logic [5:0]       tile_bank
);

    s16_pkg::io_group_t group;
    logic [7:0]         sys_inputs;
    logic [7:0]         joy_sel;
    logic               lo_wr;

    assign group = s16_pkg::io_group_t'(bus.addr[13:12]);
    assign lo_wr = !bus.rnw && !bus.lds_n;

    // Coins, test, service, starts
    assign sys_inputs = {2'b11, start_button[1:0], service, dip_test, coin_input[1:0]};

    always_comb begin
        case (bus.addr[2:1])
            2'd0:    joy_sel = joystick1;
            2'd1:    joy_sel = joystick2;
            2'd2:    joy_sel = joystick3;
            default: joy_sel = joystick4;
        endcase
    end

    always_comb begin
        case (group)
            s16_pkg::IO_SYSTEM: cab_dout = sys_inputs;
            s16_pkg::IO_PLAYER: cab_dout = joy_sel;
            s16_pkg::IO_DIP:    cab_dout = bus.addr[1] ? dipsw_b : dipsw_a;
            default:            cab_dout = s16_pkg::OPEN_BUS_BYTE;
        endcase
    end

    // Video control lives in the system group
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            video_en <= 1'b0;
            flip     <= 1'b0;
        end else if (cs.io && group == s16_pkg::IO_SYSTEM && lo_wr) begin
            video_en <= bus.wdata[5];
            flip     <= bus.wdata[6];
        end
    end

    // Two 3-bit halves, picked by A1
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tile_bank <= '0;
        end else if (cs.tbank && lo_wr) begin
            if (bus.addr[1])
                tile_bank[5:3] <= bus.wdata[2:0];
            else
                tile_bank[2:0] <= bus.wdata[2:0];
        end
    end

endmodule

//--- s16_main_bus.sv
/*
 * System 16B main board glue, seen from the 68000 bus.
 * No CPU, mapper, MCU or decryption inside; one clock domain.
 */
`timescale 1ns/10ps

module s16_main_bus (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [7:0]                    game_id,
    // CPU bus
    input  logic [23:1]                   addr,
    input  logic                          as_n,
    input  logic                          uds_n,
    input  logic                          lds_n,
    input  logic                          rnw,
    input  logic [s16_pkg::DATA_W-1:0]    wdata,
    // Cabinet
    input  logic [7:0]                    joystick1,
    input  logic [7:0]                    joystick2,
    input  logic [7:0]                    joystick3,
    input  logic [7:0]                    joystick4,
    input  logic [3:0]                    start_button,
    input  logic [3:0]                    coin_input,
    input  logic                          service,
    input  logic                          dip_test,
    input  logic [7:0]                    dipsw_a,
    input  logic [7:0]                    dipsw_b,
    // Memories
    input  logic [s16_pkg::DATA_W-1:0]    ram_data,
    input  logic [s16_pkg::DATA_W-1:0]    rom_data,
    input  logic [s16_pkg::DATA_W-1:0]    char_dout,
    input  logic [s16_pkg::DATA_W-1:0]    pal_dout,
    input  logic [s16_pkg::DATA_W-1:0]    obj_dout,
    input  logic                          ram_ok,
    input  logic                          rom_ok,
    output logic                          rom_cs,
    output logic                          ram_cs,
    output logic                          vram_cs,
    output logic                          char_cs,
    output logic                          objram_cs,
    output logic                          pal_cs,
    output logic [s16_pkg::ROM_AW-1:0]    rom_addr,
    output logic [s16_pkg::DATA_W-1:0]    cpu_din,
    output logic                          dtack_n,
    output logic                          flip,
    output logic                          video_en,
    output logic [5:0]                    tile_bank
);

    s16_pkg::s16_cs_t cs;
    logic [7:0]       cab_dout;

    s16_bus_if bus ();

    assign bus.addr  = addr;
    assign bus.as_n  = as_n;
    assign bus.uds_n = uds_n;
    assign bus.lds_n = lds_n;
    assign bus.rnw   = rnw;
    assign bus.wdata = wdata;

    // Memory-side selects
    assign rom_cs    = cs.rom;
    assign ram_cs    = cs.ram;
    assign vram_cs   = cs.vram;
    assign char_cs   = cs.chr;
    assign objram_cs = cs.obj;
    assign pal_cs    = cs.pal;

    s16_mem_map u_mem_map (
        .clk      (clk),
        .rst      (rst),
        .bus      (bus),
        .game_id  (game_id),
        .cs       (cs),
        .rom_addr (rom_addr)
    );

    s16_io_ports u_io_ports (
        .clk          (clk),
        .rst          (rst),
        .bus          (bus),
        .cs           (cs),
        .joystick1    (joystick1),
        .joystick2    (joystick2),
        .joystick3    (joystick3),
        .joystick4    (joystick4),
        .start_button (start_button),
        .coin_input   (coin_input),
        .service      (service),
        .dip_test     (dip_test),
        .dipsw_a      (dipsw_a),
        .dipsw_b      (dipsw_b),
        .cab_dout     (cab_dout),
        .flip         (flip),
        .video_en     (video_en),
        .tile_bank    (tile_bank)
    );

    s16_data_return u_data_return (
        .clk       (clk),
        .rst       (rst),
        .cs        (cs),
        .ram_data  (ram_data),
        .rom_data  (rom_data),
        .char_dout (char_dout),
        .pal_dout  (pal_dout),
        .obj_dout  (obj_dout),
        .cab_dout  (cab_dout),
        .ram_ok    (ram_ok),
        .rom_ok    (rom_ok),
        .cpu_din   (cpu_din),
        .dtack_n   (dtack_n)
    );

endmodule

//--- s16_mem_map.sv
/*
 * Board variant decode, chip selects and ROM banking.
 * Selects are registered and clear as soon as as_n is sampled high.
 * No programmable mapper: the region is addr[23:21].
 */
`timescale 1ns/10ps

module s16_mem_map (
    input  logic                          clk,
    input  logic                          rst,
    s16_bus_if.decoder                    bus,
    input  logic [7:0]                    game_id,
    output s16_pkg::s16_cs_t              cs,
    output logic [s16_pkg::ROM_AW-1:0]    rom_addr
);

    s16_pkg::pcb_t    pcb;
    s16_pkg::pcb_t    pcb_next;
    s16_pkg::s16_cs_t cs_next;
    logic [2:0]       region;
    logic [1:0]       bank;
    logic             strobe;    // Either data strobe active
    logic             is_5797;

    assign region  = bus.addr[23:21];
    assign bank    = region[1:0];    // Only meaningful in regions 0 to 2
    assign strobe  = !(bus.uds_n && bus.lds_n);
    assign is_5797 = (pcb == s16_pkg::PCB_5797);

    // Variant from game ID bits 7:3
    always_comb begin
        casez (game_id[7:3])
            5'b001??: pcb_next = s16_pkg::PCB_5797;
            5'b0001?: begin
                if (game_id == 8'h10 || game_id == 8'h15 || game_id == 8'h1a)
                    pcb_next = s16_pkg::PCB_5358_LARGE;
                else
                    pcb_next = s16_pkg::PCB_5358_SMALL;
            end
            5'b00001: pcb_next = s16_pkg::PCB_KOREAN;
            default:  pcb_next = s16_pkg::PCB_5521;    // Also covers 5704
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            pcb <= s16_pkg::PCB_5521;
        else
            pcb <= pcb_next;
    end

    // Select decode for the current address
    always_comb begin
        cs_next = '0;
        if (is_5797)
            cs_next.rom = (region == 3'd0) && bus.rnw;
        else
            cs_next.rom = (region <= 3'd2) && bus.rnw;

        cs_next.chr  = (region == s16_pkg::REGION_VRAM) && bus.addr[16];
        cs_next.vram = (region == s16_pkg::REGION_VRAM) && !bus.addr[16] && strobe;
        cs_next.ram  = (region == s16_pkg::REGION_RAM) && strobe;
        cs_next.obj  = (region == s16_pkg::REGION_ORAM);
        cs_next.pal  = (region == s16_pkg::REGION_PAL);
        cs_next.io   = (region == s16_pkg::REGION_IO);

        // 5797 shares regions 1 and 2 with the dropped multiplier and timers
        if (is_5797)
            cs_next.tbank = (region == 3'd1 || region == 3'd2)
                            && bus.addr[13:12] == 2'd2 && !bus.rnw;
        else
            cs_next.tbank = (region == 3'd2) && !bus.rnw;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            cs <= '0;
        else if (!bus.as_n)
            cs <= cs_next;
        else
            cs <= '0;    // Drop everything at end of cycle
    end

    // ROM bank translation, combinational
    always_comb begin
        case (pcb)
            s16_pkg::PCB_5797:       rom_addr = bus.addr[18:1];
            s16_pkg::PCB_5358_LARGE: rom_addr = {bank, bus.addr[16:1]};
            s16_pkg::PCB_5358_SMALL: rom_addr = {1'b0, bank, bus.addr[15:1]};
            s16_pkg::PCB_KOREAN:     rom_addr = {1'b0, bus.addr[17:1]};
            default:                 rom_addr = {bank[0], bus.addr[17:1]};   // 512 kB
        endcase
    end

endmodule

//--- s16_pkg.sv
/*
 * Shared constants and types for the System 16B main bus glue.
 * Regions are the top three word address bits, 2 MB each.
 */
package s16_pkg;

    // Bus widths
    localparam int ADDR_W = 23;   // Word address, bits 23:1
    localparam int DATA_W = 16;
    localparam int ROM_AW = 18;   // Banked ROM word address

    // Regions 0 to 2 belong to the program ROM
    localparam logic [2:0] REGION_RAM  = 3'd3;
    localparam logic [2:0] REGION_ORAM = 3'd4;
    localparam logic [2:0] REGION_VRAM = 3'd5;
    localparam logic [2:0] REGION_PAL  = 3'd6;
    localparam logic [2:0] REGION_IO   = 3'd7;

    localparam logic [7:0] OPEN_BUS_BYTE = 8'hff;   // Undriven byte reads high

    // Board variants, taken from the game ID
    typedef enum logic [2:0] {
        PCB_5521,
        PCB_5358_SMALL,
        PCB_5358_LARGE,
        PCB_5797,
        PCB_KOREAN
    } pcb_t;

    // I/O groups, address bits 13:12
    typedef enum logic [1:0] {
        IO_SYSTEM = 2'd0,
        IO_PLAYER = 2'd1,
        IO_DIP    = 2'd2,
        IO_OPEN   = 2'd3
    } io_group_t;

    // Registered chip selects
    typedef struct packed {
        logic rom;
        logic ram;
        logic vram;
        logic chr;    // Character RAM
        logic obj;
        logic pal;
        logic io;
        logic tbank;  // Tile bank register write
    } s16_cs_t;

endpackage

//--- tb_s16_main_bus.sv
/*
 * Directed testbench for s16_main_bus. The memory models answer with the
 * word address XOR a random key. rom_ok and ram_ok stay high unless a test stalls them.
 */
`timescale 1ns/10ps

module tb_s16_main_bus;

    localparam int ACK_TIMEOUT = 16;    // Cycles

    logic                          clk, rst, as_n, uds_n, lds_n, rnw;
    logic [7:0]                    game_id, dipsw_a, dipsw_b;
    logic [7:0]                    joystick1, joystick2, joystick3, joystick4;
    logic [3:0]                    start_button, coin_input;
    logic                          service, dip_test, ram_ok, rom_ok;
    logic [23:1]                   addr;
    logic [s16_pkg::DATA_W-1:0]    wdata, ram_data, rom_data, char_dout, pal_dout, obj_dout;
    logic [s16_pkg::DATA_W-1:0]    cpu_din;
    logic                          rom_cs, ram_cs, vram_cs, char_cs, objram_cs, pal_cs;
    logic                          dtack_n, flip, video_en;
    logic [s16_pkg::ROM_AW-1:0]    rom_addr;
    logic [5:0]                    tile_bank;
    logic [5:0]                    sels;

    integer      seed;
    logic [31:0] rnd;
    logic [15:0] rom_key, ram_key, vid_key;
    int          errors = 0;
    int          tests = 0;
    int          failed_tests = 0;

    assign sels = {rom_cs, ram_cs, vram_cs, char_cs, objram_cs, pal_cs};

    s16_main_bus u_s16_main_bus (.*);

    always #20 clk = ~clk;

    task automatic check_word(input string what, input logic [s16_pkg::DATA_W-1:0] got,
                              input logic [s16_pkg::DATA_W-1:0] exp);
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_rom_addr(input string what, input logic [s16_pkg::ROM_AW-1:0] got,
                                  input logic [s16_pkg::ROM_AW-1:0] exp);
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_tile_bank(input logic [5:0] got, input logic [5:0] exp);
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: tile_bank is %b, expected %b", $time, got, exp);
        end
    endtask

    // Bit order rom ram vram char obj pal
    task automatic check_selects(input logic [5:0] got, input logic [5:0] exp);
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: selects are %b, expected %b", $time, got, exp);
        end
    endtask

    task automatic end_test(input string name, input int errors_before);
        tests++;
        if (errors == errors_before) begin
            $display("%-12s ok", name);
        end else begin
            failed_tests++;
            $display("%-12s failed, %0d errors", name, errors - errors_before);
        end
    endtask

    // Takes a byte address and drops bit 0
    task automatic bus_start(input logic [23:0] a, input logic rd, input logic u,
                             input logic l, input logic [15:0] d);
        @(negedge clk);
        addr      = a[23:1];
        {rnw, uds_n, lds_n} = {rd, u, l};
        wdata     = d;
        rom_data  = a[16:1] ^ rom_key;
        ram_data  = a[16:1] ^ ram_key;
        char_dout = a[16:1] ^ vid_key;
        pal_dout  = a[16:1] ^ vid_key;
        obj_dout  = a[16:1] ^ vid_key;
        as_n      = 1'b0;
    endtask

    task automatic bus_stop();
        @(negedge clk);
        {as_n, uds_n, lds_n, rnw} = 4'hf;
    endtask

    task automatic await_ack(input logic [23:0] a);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (dtack_n && n < ACK_TIMEOUT);
        if (dtack_n) begin
            errors++;
            $display("timeout at %0t: dtack_n never went low for address %h", $time, a);
        end
    endtask

    task automatic bus_read(input logic [23:0] a, output logic [15:0] d);
        bus_start(a, 1'b1, 1'b0, 1'b0, '0);
        await_ack(a);
        @(negedge clk);    // Data lands one cycle after the select
        d = cpu_din;
        bus_stop();
    endtask

    // Lower-byte write that expects dtack_n to stay high when acked is low
    task automatic bus_write(input logic [23:0] a, input logic [15:0] d, input logic acked);
        bus_start(a, 1'b0, 1'b1, 1'b0, d);
        if (acked) begin
            await_ack(a);
        end else begin
            repeat (3) begin
                @(negedge clk);
                check_bit("dtack_n", dtack_n, 1'b1);
            end
        end
        bus_stop();
    endtask

    task automatic probe(input logic [23:0] a, input logic rd, input logic u, input logic l,
                         input logic [5:0] exp);
        bus_start(a, rd, u, l, 16'h1234);
        @(negedge clk);
        check_selects(sels, exp);
        bus_stop();
    endtask

    task automatic set_board(input logic [7:0] id);
        @(negedge clk);
        game_id = id;
        repeat (2) @(negedge clk);
    endtask

    // Bank is the region number a[23:21]
    function automatic logic [s16_pkg::ROM_AW-1:0] rom_expect(input s16_pkg::pcb_t board,
                                                              input logic [23:0] a);
        case (board)
            s16_pkg::PCB_5797:       return a[18:1];
            s16_pkg::PCB_5358_LARGE: return {a[22:21], a[16:1]};
            s16_pkg::PCB_5358_SMALL: return {1'b0, a[22:21], a[15:1]};
            s16_pkg::PCB_KOREAN:     return {1'b0, a[17:1]};
            default:                 return {a[21], a[17:1]};
        endcase
    endfunction

    task automatic test_reset();
        int e;
        e = errors;
        @(negedge clk);
        check_selects(sels, 6'b000000);
        check_bit("dtack_n", dtack_n, 1'b1);
        check_tile_bank(tile_bank, 6'd0);
        check_bit("flip", flip, 1'b0);
        check_bit("video_en", video_en, 1'b0);
        end_test("reset", e);
    endtask

    task automatic test_rom_banking();
        logic [7:0]    ids [5];
        s16_pkg::pcb_t boards [5];
        logic [23:0]   a;
        logic          hit;
        int            e;
        e = errors;
        ids = '{8'h40, 8'h11, 8'h15, 8'h20, 8'h08};
        boards = '{s16_pkg::PCB_5521, s16_pkg::PCB_5358_SMALL, s16_pkg::PCB_5358_LARGE,
                   s16_pkg::PCB_5797, s16_pkg::PCB_KOREAN};
        for (int b = 0; b < 5; b++) begin
            set_board(ids[b]);
            for (int r = 0; r < 3; r++) begin
                rnd = $random(seed);
                a = {r[2:0], rnd[20:1], 1'b0};
                hit = (boards[b] != s16_pkg::PCB_5797) || (r == 0);
                bus_start(a, 1'b1, 1'b0, 1'b0, '0);
                @(negedge clk);
                check_bit("rom_cs", rom_cs, hit);
                if (hit)
                    check_rom_addr("rom_addr", rom_addr, rom_expect(boards[b], a));
                bus_stop();
            end
            probe(24'h00_1230, 1'b0, 1'b1, 1'b0, 6'b000000);   // ROM is read only
        end
        end_test("rom banking", e);
    endtask

    task automatic test_decode();
        int e;
        e = errors;
        set_board(8'h40);
        probe(24'h60_1000, 1'b1, 1'b0, 1'b0, 6'b010000);
        probe(24'h60_1000, 1'b1, 1'b1, 1'b1, 6'b000000);   // RAM needs a data strobe
        probe(24'h80_0200, 1'b1, 1'b0, 1'b0, 6'b000010);
        probe(24'hc0_0400, 1'b1, 1'b0, 1'b0, 6'b000001);
        probe(24'ha0_0800, 1'b1, 1'b0, 1'b0, 6'b001000);
        probe(24'ha1_0800, 1'b1, 1'b0, 1'b0, 6'b000100);   // A16 picks char RAM
        end_test("decode", e);
    endtask

    task automatic stalled_read(input logic [23:0] a, input logic from_rom);
        logic [15:0] exp;
        logic [15:0] held;
        exp = a[16:1] ^ (from_rom ? rom_key : ram_key);
        @(negedge clk);
        rom_ok = !from_rom;
        ram_ok = from_rom;
        held = cpu_din;
        bus_start(a, 1'b1, 1'b0, 1'b0, '0);
        repeat (5) begin
            @(negedge clk);
            check_bit("dtack_n", dtack_n, 1'b1);
            check_word("cpu_din", cpu_din, held);    // Old data stays during the wait
        end
        {rom_ok, ram_ok} = 2'b11;
        await_ack(a);
        @(negedge clk);
        check_word("cpu_din", cpu_din, exp);
        bus_stop();
    endtask

    task automatic test_wait_states();
        int e;
        e = errors;
        stalled_read(24'h60_2468, 1'b0);
        stalled_read(24'h23_4566, 1'b1);
        end_test("wait states", e);
    endtask

    task automatic test_cabinet();
        logic [15:0] d;
        logic [7:0]  joy [4];
        int          e;
        e = errors;
        joy = '{joystick1, joystick2, joystick3, joystick4};
        bus_read(24'he0_0000, d);
        check_word("system", d, {8'hff, 2'b11, start_button[1:0], service, dip_test,
                                 coin_input[1:0]});
        for (int i = 0; i < 4; i++) begin
            bus_read({12'he01, 9'd0, i[1:0], 1'b0}, d);
            check_word("joystick", d, {8'hff, joy[i]});
        end
        bus_read(24'he0_2000, d);
        check_word("dip a", d, {8'hff, dipsw_a});
        bus_read(24'he0_2002, d);
        check_word("dip b", d, {8'hff, dipsw_b});
        bus_write(24'he0_0000, 16'h0040, 1'b1);    // Flip only
        check_bit("flip", flip, 1'b1);
        check_bit("video_en", video_en, 1'b0);
        bus_write(24'he0_0000, 16'h0020, 1'b1);    // Video enable only
        check_bit("flip", flip, 1'b0);
        check_bit("video_en", video_en, 1'b1);
        end_test("cabinet", e);
    endtask

    task automatic bank_write(input logic [23:0] a, input logic [15:0] d, input logic hit,
                              inout logic [5:0] exp);
        bus_write(a, d, hit);
        if (hit && a[1])
            exp[5:3] = d[2:0];
        else if (hit)
            exp[2:0] = d[2:0];
        check_tile_bank(tile_bank, exp);
    endtask

    task automatic test_tile_bank();
        logic [5:0] exp;
        int         e;
        e = errors;
        exp = 6'd0;
        set_board(8'h40);
        bank_write(24'h40_0000, 16'h0005, 1'b1, exp);
        bank_write(24'h40_0002, 16'h0003, 1'b1, exp);
        bank_write(24'h20_0002, 16'h0007, 1'b0, exp);      // Region 1 is not the register
        set_board(8'h20);
        bank_write(24'h20_2000, 16'h0006, 1'b1, exp);
        bank_write(24'h40_2002, 16'h0001, 1'b1, exp);
        bank_write(24'h40_1002, 16'h0004, 1'b0, exp);      // Wrong group on 5797
        end_test("tile bank", e);
    endtask

    initial begin
        seed = 32'hba35_dde7;
        rnd = $random(seed);
        {rom_key, ram_key} = rnd;
        rnd = $random(seed);
        vid_key = rnd[15:0];
        clk = 1'b0;
        rst = 1'b1;
        game_id = 8'h40;
        addr = '0;
        wdata = '0;
        {as_n, uds_n, lds_n, rnw} = 4'hf;
        {ram_ok, rom_ok, service, dip_test} = 4'b1110;
        {joystick1, joystick2, joystick3, joystick4} = 32'ha1b2_c3d4;
        {start_button, coin_input} = 8'h96;
        {dipsw_a, dipsw_b} = 16'h5a3c;
        {rom_data, ram_data, char_dout, pal_dout, obj_dout} = '0;
        repeat (3) @(negedge clk);
        rst = 1'b0;
        test_reset();
        test_rom_banking();
        test_decode();
        test_wait_states();
        test_cabinet();
        test_tile_bank();
        errors += u_s16_main_bus.u_bus_checker.assert_failures;
        $display("%0d tests, %0d failed, %0d errors", tests, failed_tests, errors);
        if (errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule
